/* hdl/obj_macros.svh */
// Object engine constants for table size, sprite row width and readout start
`ifndef OBJ_MACROS_SVH
`define OBJ_MACROS_SVH

// Sprite entries in the object table
`define OBJ_ENTRIES 64

// Table word address width
// Four words per entry, 256 words in all
`define OBJ_TBL_AW 8

// ROM words per sprite row
// Each word holds four 4-bit pixels, so 16 pixels per row
`define OBJ_WORDS_PER_ROW 4

// Buffer address of the first shown pixel
// Loaded into the readout counter during blanking
`define OBJ_HOBJ_START 0

`endif

/* hdl/obj_pkg.sv */
// Object engine package with vector typedefs, pixel and command structs and FSM enums
`default_nettype none

`include "obj_macros.svh"

package obj_pkg;

    // Plain vectors with a meaning
    typedef logic [`OBJ_TBL_AW-1:0] tbl_addr_t;
    typedef logic [15:0]            cpu_word_t;
    typedef logic [8:0]             xpos_t;
    typedef logic [8:0]             vpos_t;
    typedef logic [19:0]            rom_addr_t;
    // Leftmost pixel sits in the top nibble
    typedef logic [15:0]            rom_word_t;

    // Line buffer pixel
    // Colour zero means transparent
    typedef struct packed {
        logic [1:0] prio;
        logic [5:0] pal;
        logic [3:0] color;
    } obj_pxl_t;

    // One sprite row to draw
    typedef struct packed {
        xpos_t      xpos;
        logic       hflip;
        rom_addr_t  rom_addr;
        logic [1:0] prio;
        logic [5:0] pal;
    } draw_cmd_t;

    // Drawer write into the back bank
    typedef struct packed {
        xpos_t    addr;
        obj_pxl_t data;
    } buf_wr_t;

    // Literals carry a prefix so both machines share one package
    typedef enum logic [1:0] {SCAN_IDLE, SCAN_READ, SCAN_CHECK, SCAN_ISSUE} scan_state_t;
    typedef enum logic [1:0] {DRAW_IDLE, DRAW_FETCH, DRAW_UNPACK} draw_state_t;

endpackage

`default_nettype wire

/* hdl/obj_ram.sv */
// Object table RAM with CPU byte-lane writes, CPU readback and a scan read port
`timescale 1ns/1ps
`default_nettype none

`include "obj_macros.svh"

module obj_ram import obj_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n,
    // CPU side
    input  wire logic      cpu_obj_cs,
    input  wire tbl_addr_t cpu_addr,
    input  wire cpu_word_t cpu_dout,
    input  wire logic [1:0] dsn,
    output cpu_word_t      cpu_din,
    // Scanner side
    input  wire tbl_addr_t tbl_addr,
    output cpu_word_t      tbl_dout
);

    localparam int DEPTH = 2 ** `OBJ_TBL_AW;

    // Four words per sprite entry
    cpu_word_t mem [DEPTH];

    logic we_lo;
    logic we_hi;

    // Active-low strobes, bit 1 is the upper byte
    assign we_lo = cpu_obj_cs && !dsn[0];
    assign we_hi = cpu_obj_cs && !dsn[1];

    // Byte lanes written on their own
    always_ff @(posedge clk) begin
        if (we_lo) begin
            mem[cpu_addr][7:0] <= cpu_dout[7:0];
        end
        if (we_hi) begin
            mem[cpu_addr][15:8] <= cpu_dout[15:8];
        end
    end

    // Registered reads on both ports
    // Same-cycle write shows up one cycle later
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cpu_din  <= '0;
            tbl_dout <= '0;
        end else begin
            cpu_din  <= mem[cpu_addr];
            tbl_dout <= mem[tbl_addr];
        end
    end

endmodule

`default_nettype wire

/* hdl/obj_scan.sv */
// Object table scanner selecting the sprites on a line and issuing draw commands
`timescale 1ns/1ps
`default_nettype none

`include "obj_macros.svh"

module obj_scan import obj_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      hstart,
    input  wire vpos_t     vrender,
    // Table read port
    output tbl_addr_t      tbl_addr,
    input  wire cpu_word_t tbl_dout,
    // Draw commands
    output logic           dr_start,
    output draw_cmd_t      dr_cmd,
    input  wire logic      dr_busy
);

    localparam int EW = $clog2(`OBJ_ENTRIES);
    localparam logic [EW-1:0] LAST_ENTRY = EW'(`OBJ_ENTRIES - 1);

    scan_state_t   state;
    logic [EW-1:0] entry;
    logic [EW-1:0] entry_nxt;
    logic [1:0]    widx;
    // Word on tbl_dout and its index
    logic          rd_vld;
    logic [1:0]    rd_idx;
    vpos_t         vline;
    // Words 0 to 2 of the current entry
    cpu_word_t     w0;
    cpu_word_t     w1;
    cpu_word_t     w2;
    vpos_t         row;
    logic          hit;

    assign entry_nxt = entry + 1'b1;

    // During CHECK the next entry's first word is already requested
    assign tbl_addr = (state == SCAN_CHECK) ? {entry_nxt, 2'b00} : {entry, widx};

    // Row inside the sprite, modulo 512
    assign row = vline - vpos_t'(w0[8:0]);
    assign hit = row < vpos_t'(w2[7:0]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= SCAN_IDLE;
            entry    <= '0;
            widx     <= '0;
            rd_vld   <= 1'b0;
            rd_idx   <= '0;
            dr_start <= 1'b0;
        end else if (hstart) begin
            // New line restarts the walk
            state    <= SCAN_READ;
            entry    <= '0;
            widx     <= '0;
            rd_vld   <= 1'b0;
            dr_start <= 1'b0;
        end else begin
            dr_start <= 1'b0;
            rd_vld   <= 1'b0;
            rd_idx   <= widx;
            case (state)
                SCAN_READ: begin
                    rd_vld <= 1'b1;
                    widx   <= widx + 1'b1;
                    if (widx == 2'd3) begin
                        state <= SCAN_CHECK;
                    end
                end
                SCAN_CHECK: begin
                    // Word 3 is on tbl_dout now
                    if (w0[15]) begin
                        // Stop flag, entry itself not drawn
                        state <= SCAN_IDLE;
                    end else if (hit) begin
                        state <= SCAN_ISSUE;
                    end else if (entry == LAST_ENTRY) begin
                        state <= SCAN_IDLE;
                    end else begin
                        // Word 0 of next entry already requested
                        entry  <= entry_nxt;
                        widx   <= 2'd1;
                        rd_vld <= 1'b1;
                        rd_idx <= 2'd0;
                        state  <= SCAN_READ;
                    end
                end
                SCAN_ISSUE: begin
                    // Hold the command until the drawer is free
                    if (!dr_busy) begin
                        dr_start <= 1'b1;
                        widx     <= '0;
                        if (entry == LAST_ENTRY) begin
                            state <= SCAN_IDLE;
                        end else begin
                            entry <= entry_nxt;
                            state <= SCAN_READ;
                        end
                    end
                end
                default: state <= SCAN_IDLE;
            endcase
        end
    end

    // Capture table words and vertical position
    always_ff @(posedge clk) begin
        if (hstart) begin
            vline <= vrender;
        end
        if (rd_vld) begin
            case (rd_idx)
                2'd0: w0 <= tbl_dout;
                2'd1: w1 <= tbl_dout;
                2'd2: w2 <= tbl_dout;
                default: ;
            endcase
        end
        // Command built from words 1 to 3 on a hit
        if (state == SCAN_CHECK && hit) begin
            dr_cmd.xpos     <= xpos_t'(w1[8:0]);
            dr_cmd.hflip    <= w1[15];
            dr_cmd.rom_addr <= rom_addr_t'(tbl_dout) + rom_addr_t'({row, 2'b00});
            dr_cmd.prio     <= w2[15:14];
            dr_cmd.pal      <= w2[13:8];
        end
    end

endmodule

`default_nettype wire

/* hdl/obj_draw.sv */
// Sprite drawer with ROM fetch, pixel unpacking and line buffer writes
`timescale 1ns/1ps
`default_nettype none

`include "obj_macros.svh"

module obj_draw import obj_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      hstart,
    // From scanner
    input  wire logic      dr_start,
    input  wire draw_cmd_t dr_cmd,
    output logic           dr_busy,
    // Graphics ROM
    output logic           obj_cs,
    output rom_addr_t      obj_addr,
    input  wire logic      obj_ok,
    input  wire rom_word_t obj_data,
    // Line buffer
    output logic           buf_we,
    output buf_wr_t        buf_wr
);

    localparam logic [1:0] LAST_WORD = 2'(`OBJ_WORDS_PER_ROW - 1);

    draw_state_t state;
    logic [1:0]  word_cnt;
    logic [1:0]  nib_cnt;
    draw_cmd_t   cur;
    // Pixels left in the word, next one on top
    rom_word_t   pxl_sr;
    // Buffer position of the next pixel
    xpos_t       pos;
    logic        word_done;
    logic        row_done;

    assign word_done = (state == DRAW_UNPACK) && (nib_cnt == 2'd3);
    assign row_done  = word_done && (word_cnt == LAST_WORD);

    // Only opaque pixels reach the buffer
    assign buf_we           = (state == DRAW_UNPACK) && (pxl_sr[15:12] != 4'd0);
    assign buf_wr.addr      = pos;
    assign buf_wr.data.prio  = cur.prio;
    assign buf_wr.data.pal   = cur.pal;
    assign buf_wr.data.color = pxl_sr[15:12];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= DRAW_IDLE;
            obj_cs   <= 1'b0;
            dr_busy  <= 1'b0;
            word_cnt <= '0;
            nib_cnt  <= '0;
        end else if (hstart) begin
            // Unfinished sprite is dropped at line start
            state   <= DRAW_IDLE;
            obj_cs  <= 1'b0;
            dr_busy <= 1'b0;
        end else begin
            case (state)
                DRAW_IDLE: begin
                    if (dr_start) begin
                        state    <= DRAW_FETCH;
                        obj_cs   <= 1'b1;
                        dr_busy  <= 1'b1;
                        word_cnt <= '0;
                    end
                end
                DRAW_FETCH: begin
                    // Request held until the ROM answers
                    if (obj_ok) begin
                        obj_cs  <= 1'b0;
                        nib_cnt <= '0;
                        state   <= DRAW_UNPACK;
                    end
                end
                DRAW_UNPACK: begin
                    nib_cnt <= nib_cnt + 1'b1;
                    if (row_done) begin
                        state   <= DRAW_IDLE;
                        dr_busy <= 1'b0;
                    end else if (word_done) begin
                        word_cnt <= word_cnt + 1'b1;
                        obj_cs   <= 1'b1;
                        state    <= DRAW_FETCH;
                    end
                end
                default: state <= DRAW_IDLE;
            endcase
        end
    end

    // Command, ROM address, pixel shifter and position
    always_ff @(posedge clk) begin
        if (state == DRAW_IDLE && dr_start) begin
            cur      <= dr_cmd;
            obj_addr <= dr_cmd.rom_addr;
            // Flipped rows start at the right edge and walk left
            pos      <= dr_cmd.hflip ? dr_cmd.xpos + 9'd15 : dr_cmd.xpos;
        end
        if (state == DRAW_FETCH && obj_ok) begin
            pxl_sr <= obj_data;
        end
        if (state == DRAW_UNPACK) begin
            pxl_sr <= {pxl_sr[11:0], 4'd0};
            // Wraps at 512
            pos    <= cur.hflip ? pos - 1'b1 : pos + 1'b1;
            if (word_done && !row_done) begin
                obj_addr <= obj_addr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/obj_line_buffer.sv */
// Double-bank sprite line buffer with blanking swap, readout counter and erase on read
`timescale 1ns/1ps
`default_nettype none

`include "obj_macros.svh"

module obj_line_buffer import obj_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    lhbl,
    input  wire logic    pxl_cen,
    // Drawer writes
    input  wire logic    buf_we,
    input  wire buf_wr_t buf_wr,
    // Pixel output
    output obj_pxl_t     pxl
);

    localparam int DEPTH = 512;

    // Two banks, one shown while the other is drawn
    obj_pxl_t mem [2][DEPTH];

    logic  disp;
    logic  lhbl_d;
    logic  rd_en;
    xpos_t hobj;

    // One pixel out per strobe in the active period
    assign rd_en = lhbl && pxl_cen;

    // Bank select and readout counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            disp   <= 1'b0;
            lhbl_d <= 1'b0;
            hobj   <= xpos_t'(`OBJ_HOBJ_START);
        end else begin
            lhbl_d <= lhbl;
            // Swap as blanking begins
            if (lhbl_d && !lhbl) begin
                disp <= ~disp;
            end
            if (!lhbl) begin
                hobj <= xpos_t'(`OBJ_HOBJ_START);
            end else if (pxl_cen) begin
                hobj <= hobj + 1'b1;
            end
        end
    end

    // Back bank takes drawer writes, front bank is erased as read
    for (genvar b = 0; b < 2; b++) begin : g_bank
        always_ff @(posedge clk) begin
            if (buf_we && disp != 1'(b)) begin
                mem[b][buf_wr.addr] <= buf_wr.data;
            end else if (rd_en && disp == 1'(b)) begin
                mem[b][hobj] <= '0;
            end
        end
    end

    // Pixel held until the next strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pxl <= '0;
        end else if (rd_en) begin
            pxl <= disp ? mem[1][hobj] : mem[0][hobj];
        end
    end

endmodule

`default_nettype wire

/* hdl/obj_engine.sv */
// Sprite engine top level with object table, scanner, drawer and line buffer
`timescale 1ns/1ps
`default_nettype none

module obj_engine import obj_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       pxl_cen,
    // CPU port
    input  wire logic       cpu_obj_cs,
    input  wire tbl_addr_t  cpu_addr,
    input  wire cpu_word_t  cpu_dout,
    input  wire logic [1:0] dsn,
    output cpu_word_t       cpu_din,
    // Graphics ROM
    output logic            obj_cs,
    output rom_addr_t       obj_addr,
    input  wire logic       obj_ok,
    input  wire rom_word_t  obj_data,
    // Video timing
    input  wire logic       hstart,
    input  wire logic       lhbl,
    input  wire vpos_t      vrender,
    output obj_pxl_t        pxl
);

    // Table scan
    tbl_addr_t tbl_addr;
    cpu_word_t tbl_dout;

    // Draw commands
    logic      dr_start;
    logic      dr_busy;
    draw_cmd_t dr_cmd;

    // Buffer writes
    logic      buf_we;
    buf_wr_t   buf_wr;

    obj_ram obj_ram_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_obj_cs (cpu_obj_cs),
        .cpu_addr   (cpu_addr),
        .cpu_dout   (cpu_dout),
        .dsn        (dsn),
        .cpu_din    (cpu_din),
        .tbl_addr   (tbl_addr),
        .tbl_dout   (tbl_dout)
    );

    obj_scan obj_scan_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .hstart   (hstart),
        .vrender  (vrender),
        .tbl_addr (tbl_addr),
        .tbl_dout (tbl_dout),
        .dr_start (dr_start),
        .dr_cmd   (dr_cmd),
        .dr_busy  (dr_busy)
    );

    obj_draw obj_draw_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .hstart   (hstart),
        .dr_start (dr_start),
        .dr_cmd   (dr_cmd),
        .dr_busy  (dr_busy),
        .obj_cs   (obj_cs),
        .obj_addr (obj_addr),
        .obj_ok   (obj_ok),
        .obj_data (obj_data),
        .buf_we   (buf_we),
        .buf_wr   (buf_wr)
    );

    obj_line_buffer obj_line_buffer_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .lhbl    (lhbl),
        .pxl_cen (pxl_cen),
        .buf_we  (buf_we),
        .buf_wr  (buf_wr),
        .pxl     (pxl)
    );

endmodule

`default_nettype wire

/* sim/obj_engine_tb.sv */
// Sprite engine testbench with video timing, ROM responder, random tables and line model
`timescale 1ns/1ps
`default_nettype none

`include "obj_macros.svh"

module obj_engine_tb import obj_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    // 320 pixels at one strobe every second clock
    localparam int LINE_CLKS  = 640;
    localparam int ACT_CLKS   = 512;
    localparam int HSTART_CLK = 528;
    // Table updates start here long after the previous scan ended
    localparam int WIN_CLK    = 280;
    localparam int FRAME      = 16;
    // Frame crosses line 511 to reach the modulo rule
    localparam int VBASE      = 504;
    localparam int CASE_LINES = FRAME + 3;
    localparam int NUM_CASES  = 8;
    localparam int TEST_LINES = NUM_CASES * (CASE_LINES + 1) + 2;
    localparam int TBL_WORDS  = 4 * `OBJ_ENTRIES;

    logic       clk;
    logic       rst_n;
    logic       pxl_cen;
    logic       cpu_obj_cs;
    tbl_addr_t  cpu_addr;
    cpu_word_t  cpu_dout;
    logic [1:0] dsn;
    cpu_word_t  cpu_din;
    logic       obj_cs;
    rom_addr_t  obj_addr;
    logic       obj_ok;
    rom_word_t  obj_data;
    logic       hstart;
    logic       lhbl;
    vpos_t      vrender;
    obj_pxl_t   pxl;

    integer     seed;
    // Table copy kept by the CPU tasks
    cpu_word_t  model_tbl [TBL_WORDS];
    // Expected lines in slots by hstart line modulo 4
    obj_pxl_t   exp_line [4][512];
    logic       video_on;
    int         line_no;
    int         hcnt;
    logic       rom_pending;
    int         rom_wait;
    // Address of the open ROM request
    rom_addr_t  req_addr;
    xpos_t      x0;
    xpos_t      xb;

    obj_engine obj_engine_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .pxl_cen    (pxl_cen),
        .cpu_obj_cs (cpu_obj_cs),
        .cpu_addr   (cpu_addr),
        .cpu_dout   (cpu_dout),
        .dsn        (dsn),
        .cpu_din    (cpu_din),
        .obj_cs     (obj_cs),
        .obj_addr   (obj_addr),
        .obj_ok     (obj_ok),
        .obj_data   (obj_data),
        .hstart     (hstart),
        .lhbl       (lhbl),
        .vrender    (vrender),
        .pxl        (pxl)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Run length from the number of test lines plus table setup
    initial begin
        #((TEST_LINES * LINE_CLKS + 5000) * CLK_PERIOD);
        $display("Timeout: the test lines did not complete in the expected time");
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic compare_word(input cpu_word_t got, input cpu_word_t exp, input tbl_addr_t a);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: table word %0d reads %h, expected %h", $time, a, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "table readback mismatch");
        end
    endtask

    task automatic compare_pxl(input obj_pxl_t got, input obj_pxl_t exp, input int k);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: line %0d pixel %0d shows %h, expected %h",
                     $time, line_no, k, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "pixel mismatch");
        end
    endtask

    task automatic compare_addr(input rom_addr_t got, input rom_addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: ROM address moved to %h during the request for %h",
                     $time, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "ROM address not held");
        end
    endtask

    // Graphics data from the whole address
    // One nibble per word forced transparent
    function automatic rom_word_t rom_pattern(input rom_addr_t a);
        rom_word_t  w;
        logic [3:0] n;
        w = '0;
        for (int i = 0; i < 4; i++) begin
            n = 4'(a[3:0] + 3 * a[7:4] + a[11:8] + a[15:12] + a[19:16] + 5 * i + 1);
            if (2'(a[1:0] + i) == 2'd0) begin
                n = 4'd0;
            end
            w[15 - 4 * i -: 4] = n;
        end
        return w;
    endfunction

    // Expected line from the entry rules with later entries on top
    task automatic build_line(input vpos_t v, input int slot);
        cpu_word_t w0;
        cpu_word_t w1;
        cpu_word_t w2;
        cpu_word_t w3;
        vpos_t     row;
        rom_word_t data;
        obj_pxl_t  p;
        xpos_t     x;
        int        i;
        for (int k = 0; k < 512; k++) begin
            exp_line[slot][k] = '0;
        end
        for (int e = 0; e < `OBJ_ENTRIES; e++) begin
            w0 = model_tbl[4 * e];
            w1 = model_tbl[4 * e + 1];
            w2 = model_tbl[4 * e + 2];
            w3 = model_tbl[4 * e + 3];
            // Stop entry and everything after it stay hidden
            if (w0[15]) begin
                break;
            end
            row = v - vpos_t'(w0[8:0]);
            if (row < vpos_t'(w2[7:0])) begin
                for (int w = 0; w < `OBJ_WORDS_PER_ROW; w++) begin
                    data = rom_pattern(rom_addr_t'(w3) + rom_addr_t'(4 * row) + rom_addr_t'(w));
                    for (int n = 0; n < 4; n++) begin
                        i       = 4 * w + n;
                        p.prio  = w2[15:14];
                        p.pal   = w2[13:8];
                        p.color = data[15 - 4 * n -: 4];
                        x       = w1[15] ? xpos_t'(w1[8:0] + 15 - i) : xpos_t'(w1[8:0] + i);
                        if (p.color != 4'd0) begin
                            exp_line[slot][x] = p;
                        end
                    end
                end
            end
        end
    endtask

    // ROM answers a held request after 0 to 3 extra cycles
    // The drawer keeps obj_cs and obj_addr steady until obj_ok
    initial begin
        obj_ok      = 1'b0;
        obj_data    = '0;
        rom_pending = 1'b0;
        rom_wait    = 0;
        req_addr    = '0;
        forever begin
            @(posedge clk);
            #1;
            if (obj_ok) begin
                // Drawer took the word on this edge
                obj_ok = 1'b0;
            end else if (obj_cs) begin
                if (!rom_pending) begin
                    rom_pending = 1'b1;
                    rom_wait    = $unsigned($random(seed)) % 4;
                    req_addr    = obj_addr;
                end
                compare_addr(obj_addr, req_addr);
                if (rom_wait == 0) begin
                    obj_ok      = 1'b1;
                    obj_data    = rom_pattern(obj_addr);
                    rom_pending = 1'b0;
                end else begin
                    rom_wait = rom_wait - 1;
                end
            end else if (rom_pending) begin
                $display("The drawer dropped its ROM request for %h before obj_ok", req_addr);
                $display("SIMULATION FAILED");
                $fatal(1, "ROM request dropped");
            end
        end
    end

    // Video timing and pixel checks
    // Line j shows what the hstart of line j-2 drew
    initial begin
        lhbl    = 1'b0;
        pxl_cen = 1'b0;
        hstart  = 1'b0;
        vrender = '0;
        line_no = 0;
        hcnt    = 0;
        wait (video_on);
        forever begin
            for (int c = 0; c < LINE_CLKS; c++) begin
                @(posedge clk);
                #1;
                // Strobe of the last clock is on pxl now
                if (line_no >= 2 && pxl_cen && lhbl) begin
                    compare_pxl(pxl, exp_line[(line_no + 2) % 4][hcnt / 2], hcnt / 2);
                end
                hcnt    = c;
                lhbl    = (c < ACT_CLKS);
                pxl_cen = (c % 2 == 0);
                hstart  = (c == HSTART_CLK);
                if (hstart) begin
                    vrender = vpos_t'(VBASE + (line_no + 1) % FRAME);
                    build_line(vrender, line_no % 4);
                end
            end
            line_no++;
        end
    end

    task automatic cpu_write(input tbl_addr_t a, input cpu_word_t d, input logic [1:0] m);
        @(posedge clk);
        #1;
        cpu_obj_cs = 1'b1;
        cpu_addr   = a;
        cpu_dout   = d;
        dsn        = m;
        // Active-low lanes with bit 1 on the upper byte
        if (!m[0]) begin
            model_tbl[a][7:0] = d[7:0];
        end
        if (!m[1]) begin
            model_tbl[a][15:8] = d[15:8];
        end
        @(posedge clk);
        #1;
        cpu_obj_cs = 1'b0;
        dsn        = 2'b11;
    endtask

    task automatic cpu_check(input tbl_addr_t a);
        @(posedge clk);
        #1;
        cpu_addr = a;
        @(posedge clk);
        #1;
        compare_word(cpu_din, model_tbl[a], a);
    endtask

    task automatic write_entry(input int e, input logic stop, input vpos_t y, input xpos_t x,
                               input logic flip, input logic [7:0] h, input logic [5:0] pal,
                               input logic [1:0] prio, input cpu_word_t base);
        cpu_write(tbl_addr_t'(4 * e), {stop, 6'd0, y}, 2'b00);
        cpu_write(tbl_addr_t'(4 * e + 1), {flip, 6'd0, x}, 2'b00);
        cpu_write(tbl_addr_t'(4 * e + 2), {prio, pal, h}, 2'b00);
        cpu_write(tbl_addr_t'(4 * e + 3), base, 2'b00);
    endtask

    task automatic stop_at(input int e);
        cpu_write(tbl_addr_t'(4 * e), 16'h8000, 2'b00);
    endtask

    // Sprite near xbase somewhere in the frame
    task automatic random_entry(input int e, input xpos_t xbase);
        cpu_word_t  r;
        vpos_t      y;
        xpos_t      x;
        logic [7:0] h;
        r = cpu_word_t'($random(seed));
        y = vpos_t'(VBASE - 4 + $unsigned($random(seed)) % (FRAME + 4));
        x = xbase + xpos_t'($unsigned($random(seed)) % 40);
        h = 8'(1 + $unsigned($random(seed)) % 20);
        write_entry(e, 1'b0, y, x, r[15], h, r[5:0], r[7:6], cpu_word_t'($random(seed)));
    endtask

    task automatic wait_window();
        while (hcnt != WIN_CLK) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_lines(input int n);
        int target;
        target = line_no + n;
        while (line_no < target) begin
            @(posedge clk);
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        cpu_obj_cs = 1'b0;
        cpu_addr   = '0;
        cpu_dout   = '0;
        dsn        = 2'b11;
        video_on   = 1'b0;
        seed       = 69;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Known table first, then random byte-masked writes
        for (int a = 0; a < TBL_WORDS; a++) begin
            cpu_write(tbl_addr_t'(a), '0, 2'b00);
        end
        repeat (300) begin
            cpu_write(tbl_addr_t'($random(seed)), cpu_word_t'($random(seed)), 2'($random(seed)));
        end
        for (int a = 0; a < TBL_WORDS; a++) begin
            cpu_check(tbl_addr_t'(a));
        end
        for (int a = 0; a < TBL_WORDS; a++) begin
            cpu_write(tbl_addr_t'(a), '0, 2'b00);
        end
        video_on = 1'b1;

        // Single sprite plain, then flipped
        x0 = xpos_t'($unsigned($random(seed)) % 240);
        for (int f = 0; f < 2; f++) begin
            wait_window();
            write_entry(0, 1'b0, vpos_t'(VBASE + 2), x0, 1'(f), 8'd10, 6'h2a, 2'd1, 16'h1230);
            stop_at(1);
            wait_lines(CASE_LINES);
        end

        // Overlapping sprites with random ROM delays throughout
        for (int r = 0; r < 3; r++) begin
            wait_window();
            xb = xpos_t'($random(seed));
            for (int e = 0; e < 8; e++) begin
                random_entry(e, xb);
            end
            stop_at(8);
            wait_lines(CASE_LINES);
        end

        // Entries from the stop flag on cover the frame but stay hidden
        wait_window();
        for (int e = 0; e < 3; e++) begin
            random_entry(e, 9'd60);
        end
        write_entry(3, 1'b1, vpos_t'(VBASE), 9'd20, 1'b0, 8'(FRAME), 6'h11, 2'd2, 16'h0400);
        for (int e = 4; e < 7; e++) begin
            write_entry(e, 1'b0, vpos_t'(VBASE), xpos_t'(40 * e), 1'b0, 8'(FRAME),
                        6'h3f, 2'd3, 16'h0800);
        end
        wait_lines(CASE_LINES);

        // Sprite moved out of the frame
        wait_window();
        cpu_write(tbl_addr_t'(0), {7'd0, vpos_t'(VBASE - 100)}, 2'b00);
        stop_at(1);
        wait_lines(CASE_LINES);

        // Empty table
        wait_window();
        stop_at(0);
        wait_lines(CASE_LINES);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+hdl
hdl/obj_pkg.sv
hdl/obj_ram.sv
hdl/obj_scan.sv
hdl/obj_draw.sv
hdl/obj_line_buffer.sv
hdl/obj_engine.sv
sim/obj_engine_tb.sv

/* Bender.yml */
package:
  name: obj_engine

sources:
  # Sprite engine RTL, package first
  - include_dirs:
      - hdl
    files:
      - hdl/obj_pkg.sv
      - hdl/obj_ram.sv
      - hdl/obj_scan.sv
      - hdl/obj_draw.sv
      - hdl/obj_line_buffer.sv
      - hdl/obj_engine.sv

  # Testbench
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/obj_engine_tb.sv
